// File: filelist.f
+incdir+include
src/excPkg.sv
src/cp0Bypass.sv
src/excArbiter.sv
src/cp0RegFile.sv
src/excSubsystem.sv
bench/excSubsystemTb.sv

// File: Makefile
# Verilator build and run for the exception subsystem testbench

VERILATOR ?= verilator
TOP       ?= excSubsystemTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: help build test clean

help:
	@echo "make test   build, run the testbench, search $(LOG) for the pass line"
	@echo "make build  compile only, into $(BUILD_DIR)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/excSubsystemTb.sv
`timescale 1ns/1ps

`include "excUnit_params.svh"

module excSubsystemTb import excPkg::*; ();

    localparam int APB_TIMEOUT = 16;       // cycles to wait for pready
    localparam int MAX_CYCLES  = 5000;     // whole run
    localparam int PRIO_TRIALS = 24;

    localparam logic [7:0] ADDR_STATUS   = {1'b0, `CP0_REG_STATUS, 2'b00};
    localparam logic [7:0] ADDR_CAUSE    = {1'b0, `CP0_REG_CAUSE, 2'b00};
    localparam logic [7:0] ADDR_EPC      = {1'b0, `CP0_REG_EPC, 2'b00};
    localparam logic [7:0] ADDR_UNMAPPED = 8'h00;

    localparam logic [31:0] STATUS_IE  = 32'h0000_0001;
    localparam logic [31:0] STATUS_EXL = 32'h0000_0002;
    localparam logic [31:0] STATUS_IM2 = 32'h0000_0400;     // pairs with hwInt[0]

    logic                   clk;
    logic                   rstN;
    memStageT               memStage;
    cp0WrT                  cp0Wr;
    logic [5:0]             hwInt;
    apbReqT                 apbReq;
    apbRspT                 apbRsp;
    flushT                  flush;
    excActionT              excAction;
    excTypeT                excType;
    logic [4:0]             excCode;
    regsWrT                 regsWr;
    logic [`EXC_DATA_W-1:0] redirectPc;
    logic [31:0]            rngState = 32'd50;

    excSubsystem excSubsystem_i (
        .clk          (clk),
        .rstN_i       (rstN),
        .memStage_i   (memStage),
        .cp0Wr_i      (cp0Wr),
        .hwInt_i      (hwInt),
        .apbReq_i     (apbReq),
        .apbRsp_o     (apbRsp),
        .flush_o      (flush),
        .excAction_o  (excAction),
        .excType_o    (excType),
        .excCode_o    (excCode),
        .regsWr_o     (regsWr),
        .redirectPc_o (redirectPc)
    );

    // ****************************************
    // helpers
    // ****************************************
    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            failRun($sformatf("Error %s expected %h actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);    // xorshift32
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // highest set flag wins, msb is highest priority
    function automatic excTypeT topFlag(input excTypeT f);
        logic [8:0] bits;
        bits = f;
        for (int b = 8; b >= 0; b--) begin
            if (bits[b]) begin
                return excTypeT'(9'b1 << b);
            end
        end
        return '0;
    endfunction

    function automatic logic [4:0] codeOf(input excTypeT t);
        case (1'b1)
            t.fetchAddrErr, t.loadAddrErr: return `EXC_CODE_ADEL;
            t.reservedInstr:               return `EXC_CODE_RI;
            t.syscall:                     return `EXC_CODE_SYS;
            t.breakPt:                     return `EXC_CODE_BP;
            t.overflow:                    return `EXC_CODE_OV;
            t.storeAddrErr:                return `EXC_CODE_ADES;
            default:                       return `EXC_CODE_INT;   // interrupt, eret
        endcase
    endfunction

    // one transfer as setup then access phase
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        int waitCnt;
        @(posedge clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apbReq.penable <= 1'b1;
        @(negedge clk);
        waitCnt = 0;
        while (!apbRsp.pready) begin
            if (waitCnt == APB_TIMEOUT) begin
                failRun("APB transfer timed out waiting for pready");
            end
            waitCnt++;
            @(negedge clk);
        end
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge clk);                 // write lands on this edge
        apbReq <= '0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] rdata);
        logic err;
        apbXfer(1'b0, addr, '0, rdata, err);
        checkEq("apb read slverr", 32'd0, 32'(err));
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apbXfer(1'b1, addr, wdata, rdata, err);
        checkEq("apb write slverr", 32'd0, 32'(err));
    endtask

    // instruction held in the memory stage for one cycle
    task automatic issueInstr(input memStageT ms, input cp0WrT wr);
        @(posedge clk);
        memStage <= ms;
        cp0Wr    <= wr;
        @(negedge clk);                 // outputs settled here
    endtask

    task automatic endInstr();
        @(posedge clk);                 // cp0 update edge
        memStage <= '0;
        cp0Wr    <= '0;
    endtask

    // ****************************************
    // behaviors
    // ****************************************
    task automatic checkReset();
        logic [31:0] rd;
        logic        err;
        @(negedge clk);
        checkEq("reset flush", 32'h0, 32'(flush));
        checkEq("reset action", 32'(actNone), 32'(excAction));
        apbRead(ADDR_STATUS, rd);
        checkEq("reset status", `CP0_STATUS_RESET, rd);
        apbRead(ADDR_CAUSE, rd);
        checkEq("reset cause", 32'h0, rd);
        apbRead(ADDR_EPC, rd);
        checkEq("reset epc", 32'h0, rd);
        apbXfer(1'b0, ADDR_UNMAPPED, '0, rd, err);
        checkEq("unmapped read slverr", 32'd1, 32'(err));
        checkEq("unmapped read data", 32'h0, rd);
        apbXfer(1'b1, ADDR_UNMAPPED, 32'hFFFF_FFFF, rd, err);
        checkEq("unmapped write slverr", 32'd1, 32'(err));
    endtask

    task automatic checkRegAccess();
        logic [31:0] val;
        logic [31:0] rd;
        val = nextRand();
        apbWrite(ADDR_STATUS, val);
        apbRead(ADDR_STATUS, rd);
        checkEq("apb status readback", val, rd);
        val = nextRand();
        apbWrite(ADDR_EPC, val);
        apbRead(ADDR_EPC, rd);
        checkEq("apb epc readback", val, rd);
        val = nextRand();
        apbWrite(ADDR_CAUSE, val);
        apbRead(ADDR_CAUSE, rd);
        checkEq("apb cause readback", val & 32'h0000_0300, rd);   // IP[1:0] only
        val = nextRand();
        @(posedge clk);
        cp0Wr <= '{we: 1'b1, addr: `CP0_REG_EPC, data: val};
        @(posedge clk);
        cp0Wr <= '0;
        apbRead(ADDR_EPC, rd);
        checkEq("wb epc write", val, rd);
        apbWrite(ADDR_STATUS, `CP0_STATUS_RESET);    // interrupts masked again
        apbWrite(ADDR_CAUSE, 32'h0);
    endtask

    task automatic checkPriority();
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] rd;
        logic        ds;
        int          winBit;
        excTypeT     flags;
        excTypeT     exp;
        regsWrT      rw;
        for (int t = 0; t < PRIO_TRIALS; t++) begin
            r      = nextRand();
            winBit = 1 + (t % 7);       // walks loadAddrErr up to fetchAddrErr
            // winning flag forced, only lower flags are random
            flags  = excTypeT'(({r[6:0], 1'b0} & ((9'd1 << winBit) - 9'd1))
                               | (9'd1 << winBit));
            ds = r[7];
            rw = regsWrT'(r[10:8]);
            pc = (nextRand() & 32'hFFFF_FFFC) | 32'h4;
            exp = topFlag(flags);
            issueInstr('{pc: pc, isDelaySlot: ds, excType: flags, regsWr: rw}, '0);
            checkEq("prio type", 32'(exp), 32'(excType));
            checkEq("prio code", 32'(codeOf(exp)), 32'(excCode));
            checkEq("prio flush", 32'hF, 32'(flush));
            checkEq("prio regsWr", 32'h0, 32'(regsWr));
            checkEq("prio redirect", `EXC_VECTOR, redirectPc);
            checkEq("prio action", 32'(actException), 32'(excAction));
            endInstr();
            apbRead(ADDR_STATUS, rd);
            checkEq("prio exl", 32'd1, 32'(rd[1]));
            apbRead(ADDR_CAUSE, rd);
            checkEq("prio exccode", 32'(codeOf(exp)), 32'(rd[6:2]));
            checkEq("prio bd", 32'(ds), 32'(rd[31]));
            apbRead(ADDR_EPC, rd);
            checkEq("prio epc", ds ? (pc - 32'd4) : pc, rd);
            apbWrite(ADDR_STATUS, `CP0_STATUS_RESET);   // leave exception level
        end
        // bubble slot with pc 0
        rw = regsWrT'(3'b111);
        issueInstr('{pc: '0, isDelaySlot: 1'b0, excType: excTypeT'(9'h0FE), regsWr: rw}, '0);
        checkEq("bubble action", 32'(actNone), 32'(excAction));
        checkEq("bubble regsWr", 32'(rw), 32'(regsWr));
        checkEq("bubble flush", 32'h0, 32'(flush));
        checkEq("bubble type", 32'h0, 32'(excType));
        checkEq("bubble redirect", 32'h0, redirectPc);
        endInstr();
    endtask

    task automatic checkInterrupts();
        logic [31:0] rd;
        memStageT    ms;
        apbWrite(ADDR_STATUS, `CP0_STATUS_RESET | STATUS_IM2 | STATUS_IE);
        @(posedge clk);
        hwInt <= 6'b000001;
        apbRead(ADDR_CAUSE, rd);
        checkEq("int ip2 visible", 32'd1, 32'(rd[10]));
        ms = '{pc: (nextRand() & 32'hFFFF_FFFC) | 32'h4, isDelaySlot: 1'b0,
               excType: '0, regsWr: regsWrT'(3'b111)};
        issueInstr(ms, '0);
        checkEq("int action", 32'(actException), 32'(excAction));
        checkEq("int code", 32'(`EXC_CODE_INT), 32'(excCode));
        checkEq("int type", 32'h100, 32'(excType));
        endInstr();
        issueInstr(ms, '0);                         // EXL now set
        checkEq("int under exl", 32'(actNone), 32'(excAction));
        endInstr();
        apbWrite(ADDR_STATUS, `CP0_STATUS_RESET | STATUS_IE);
        issueInstr(ms, '0);
        checkEq("int im cleared", 32'(actNone), 32'(excAction));
        endInstr();
        hwInt <= '0;
    endtask

    task automatic checkEret();
        logic [31:0] epcVal;
        logic [31:0] rd;
        memStageT    ms;
        epcVal = nextRand() & 32'hFFFF_FFFC;
        apbWrite(ADDR_EPC, epcVal);
        apbWrite(ADDR_STATUS, `CP0_STATUS_RESET | STATUS_EXL);    // inside a handler
        ms = '{pc: 32'h0000_1000, isDelaySlot: 1'b0, excType: excTypeT'(9'h001),
               regsWr: regsWrT'(3'b101)};
        issueInstr(ms, '0);
        checkEq("eret action", 32'(actEret), 32'(excAction));
        checkEq("eret redirect", epcVal, redirectPc);
        checkEq("eret flush", 32'hF, 32'(flush));
        checkEq("eret type", 32'h001, 32'(excType));
        checkEq("eret regsWr", 32'h0, 32'(regsWr));
        endInstr();
        apbRead(ADDR_STATUS, rd);
        checkEq("eret exl", 32'd0, 32'(rd[1]));
        apbRead(ADDR_EPC, rd);
        checkEq("eret epc kept", epcVal, rd);
    endtask

    task automatic checkBypass();
        logic [31:0] val;
        logic [31:0] rd;
        memStageT    ms;
        // epc written back in the same cycle as eret
        apbWrite(ADDR_STATUS, `CP0_STATUS_RESET | STATUS_EXL);
        val = nextRand() & 32'hFFFF_FFFC;
        ms = '{pc: 32'h0000_2000, isDelaySlot: 1'b0, excType: excTypeT'(9'h001),
               regsWr: '0};
        issueInstr(ms, '{we: 1'b1, addr: `CP0_REG_EPC, data: val});
        checkEq("bypass eret action", 32'(actEret), 32'(excAction));
        checkEq("bypass eret redirect", val, redirectPc);
        endInstr();
        // status write dropping IE hides a pending interrupt
        apbWrite(ADDR_STATUS, `CP0_STATUS_RESET | STATUS_IM2 | STATUS_IE);
        @(posedge clk);
        hwInt <= 6'b000001;
        apbRead(ADDR_CAUSE, rd);
        checkEq("bypass ip2 visible", 32'd1, 32'(rd[10]));
        ms = '{pc: 32'h0000_3000, isDelaySlot: 1'b0, excType: '0, regsWr: '0};
        issueInstr(ms, '{we: 1'b1, addr: `CP0_REG_STATUS,
                         data: `CP0_STATUS_RESET | STATUS_IM2});
        checkEq("bypass ie clear", 32'(actNone), 32'(excAction));
        endInstr();
        hwInt <= '0;
    endtask

    // ****************************************
    // always-on checks
    // ****************************************
    // all four flushes follow the action
    assert property (@(posedge clk) disable iff (!rstN)
        (excAction == actNone) ? (flush == 4'h0) : (flush == 4'hF))
        else failRun($sformatf("Error flush vs action expected %h actual %h",
                               ($sampled(excAction) == actNone) ? 4'h0 : 4'hF,
                               $sampled(flush)));

    assert property (@(posedge clk) disable iff (!rstN)
        (excAction != actNone) |-> (regsWr == '0))
        else failRun($sformatf("Error regsWr gating expected 0 actual %h",
                               $sampled(regsWr)));

    assert property (@(posedge clk) disable iff (!rstN) apbReq.psel |-> apbRsp.pready)
        else failRun("Error apb pready expected 1 actual 0");

    // ****************************************
    // clock, reset and sequence
    // ****************************************
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        failRun("run exceeded its cycle limit without finishing");
    end

    initial begin
        rstN     = 1'b0;
        memStage = '0;
        cp0Wr    = '0;
        hwInt    = '0;
        apbReq   = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        checkReset();
        checkRegAccess();
        checkPriority();
        checkInterrupts();
        checkEret();
        checkBypass();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: src/excSubsystem.sv
`timescale 1ns/1ps

`include "excUnit_params.svh"

module excSubsystem import excPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  memStageT                memStage_i,
    input  cp0WrT                   cp0Wr_i,
    input  logic [5:0]              hwInt_i,
    input  apbReqT                  apbReq_i,
    output apbRspT                  apbRsp_o,
    output flushT                   flush_o,
    output excActionT               excAction_o,
    output excTypeT                 excType_o,
    output logic [4:0]              excCode_o,
    output regsWrT                  regsWr_o,
    output logic [`EXC_DATA_W-1:0]  redirectPc_o
);

    cp0StateT   cp0State;       // registered cp0 values
    cp0StateT   cp0Latest;      // after write-back bypass

    // ****************************************
    // input side
    // ****************************************
    cp0Bypass cp0Bypass_i (
        .cp0State_i     (cp0State),
        .cp0Wr_i        (cp0Wr_i),
        .cp0Latest_o    (cp0Latest)
    );

    // resolve, all combinational
    excArbiter excArbiter_i (
        .memStage_i     (memStage_i),
        .cp0Latest_i    (cp0Latest),
        .flush_o        (flush_o),
        .excAction_o    (excAction_o),
        .excType_o      (excType_o),
        .excCode_o      (excCode_o),
        .regsWr_o       (regsWr_o),
        .redirectPc_o   (redirectPc_o)
    );

    // ****************************************
    // output side, cp0 state
    // ****************************************
    cp0RegFile cp0RegFile_i (
        .clk            (clk),
        .rstN_i         (rstN_i),
        .hwInt_i        (hwInt_i),
        .excAction_i    (excAction_o),
        .excCode_i      (excCode_o),
        .excPc_i        (memStage_i.pc),
        .excDelaySlot_i (memStage_i.isDelaySlot),
        .cp0Wr_i        (cp0Wr_i),
        .apbReq_i       (apbReq_i),
        .apbRsp_o       (apbRsp_o),
        .cp0State_o     (cp0State)
    );

endmodule

// File: src/cp0RegFile.sv
`timescale 1ns/1ps

`include "excUnit_params.svh"

module cp0RegFile import excPkg::*; (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [5:0]              hwInt_i,        // hardware interrupt lines
    input  excActionT               excAction_i,
    input  logic [4:0]              excCode_i,
    input  logic [`EXC_DATA_W-1:0]  excPc_i,        // pc of the faulting instr
    input  logic                    excDelaySlot_i,
    input  cp0WrT                   cp0Wr_i,        // write-back cp0 write
    input  apbReqT                  apbReq_i,
    output apbRspT                  apbRsp_o,
    output cp0StateT                cp0State_o
);

    logic [`EXC_DATA_W-1:0] statusQ;
    logic [`EXC_DATA_W-1:0] causeQ;
    logic [`EXC_DATA_W-1:0] epcQ;
    logic [`EXC_DATA_W-1:0] statusD;
    logic [`EXC_DATA_W-1:0] causeD;
    logic [`EXC_DATA_W-1:0] epcD;

    logic                   apbAccess;      // second phase of a transfer
    logic                   apbWrEn;
    logic                   apbAligned;
    logic [5:0]             apbIdx;         // word index from byte address
    logic                   hitStatus;
    logic                   hitCause;
    logic                   hitEpc;
    logic                   apbHit;

    // ****************************************
    // apb decode
    // ****************************************
    assign apbAccess  = apbReq_i.psel && apbReq_i.penable;
    assign apbIdx     = apbReq_i.paddr[7:2];
    assign apbAligned = (apbReq_i.paddr[1:0] == 2'b00);

    assign hitStatus = apbAligned && (apbIdx == {1'b0, `CP0_REG_STATUS});
    assign hitCause  = apbAligned && (apbIdx == {1'b0, `CP0_REG_CAUSE});
    assign hitEpc    = apbAligned && (apbIdx == {1'b0, `CP0_REG_EPC});
    assign apbHit    = hitStatus || hitCause || hitEpc;

    assign apbWrEn = apbAccess && apbReq_i.pwrite && apbHit;   // bad addr ignored

    // ****************************************
    // next state
    // ****************************************
    // layered lowest priority first, later writes win
    always_comb begin
        statusD = statusQ;
        causeD  = causeQ;
        epcD    = epcQ;

        // apb host
        if (apbWrEn) begin
            if (hitStatus) begin
                statusD = apbReq_i.pwdata;
            end
            if (hitCause) begin
                causeD[9:8] = apbReq_i.pwdata[9:8];     // IP[1:0] only
            end
            if (hitEpc) begin
                epcD = apbReq_i.pwdata;
            end
        end

        // write-back stage
        if (cp0Wr_i.we) begin
            case (cp0Wr_i.addr)
                `CP0_REG_STATUS: statusD     = cp0Wr_i.data;
                `CP0_REG_CAUSE:  causeD[9:8] = cp0Wr_i.data[9:8];
                `CP0_REG_EPC:    epcD        = cp0Wr_i.data;
                default: begin
                    // not a register of this block
                end
            endcase
        end

        causeD[15:10] = hwInt_i;    // IP[7:2] follows the pins

        // exception entry and return
        case (excAction_i)
            actException: begin
                // nested entry keeps the first return point
                if (!statusD[1]) begin
                    epcD       = excDelaySlot_i ? (excPc_i - 'd4) : excPc_i;
                    causeD[31] = excDelaySlot_i;    // BD
                end
                statusD[1]   = 1'b1;                // EXL
                causeD[6:2]  = excCode_i;           // ExcCode
            end
            actEret: begin
                statusD[1] = 1'b0;                  // leave exception level
            end
            default: begin
                // no event this cycle
            end
        endcase
    end

    // ****************************************
    // registers
    // ****************************************
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            statusQ <= `CP0_STATUS_RESET;
            causeQ  <= '0;
            epcQ    <= '0;
        end else begin
            statusQ <= statusD;
            causeQ  <= causeD;
            epcQ    <= epcD;
        end
    end

    assign cp0State_o = '{status: statusQ, cause: causeQ, epc: epcQ};

    // apb read side, no wait states
    always_comb begin
        apbRsp_o.pready  = 1'b1;
        apbRsp_o.pslverr = apbAccess && !apbHit;
        if (hitStatus) begin
            apbRsp_o.prdata = statusQ;
        end else if (hitCause) begin
            apbRsp_o.prdata = causeQ;
        end else if (hitEpc) begin
            apbRsp_o.prdata = epcQ;
        end else begin
            apbRsp_o.prdata = '0;   // unmapped reads as zero
        end
    end

endmodule

// File: src/excArbiter.sv
`timescale 1ns/1ps

`include "excUnit_params.svh"

module excArbiter import excPkg::*; (
    input  memStageT                memStage_i,     // instr in memory stage
    input  cp0StateT                cp0Latest_i,    // bypassed cp0 values
    output flushT                   flush_o,
    output excActionT               excAction_o,
    output excTypeT                 excType_o,      // one-hot resolved event
    output logic [4:0]              excCode_o,
    output regsWrT                  regsWr_o,       // gated write enables
    output logic [`EXC_DATA_W-1:0]  redirectPc_o
);

    logic       pcValid;        // pc 0 means bubble or flushed slot
    logic       intPending;
    logic       eventHit;
    excTypeT    inFlags;
    excTypeT    resolved;

    // ****************************************
    // interrupt check
    // ****************************************
    assign inFlags = memStage_i.excType;
    assign pcValid = (memStage_i.pc != '0);

    // IP & IM nonzero, not at exception level, global enable on
    assign intPending = (|(cp0Latest_i.cause[15:8] & cp0Latest_i.status[15:8]))
                        && !cp0Latest_i.status[1]       // EXL
                        && cp0Latest_i.status[0];       // IE

    // ****************************************
    // fixed priority
    // ****************************************
    always_comb begin
        resolved  = '0;
        excCode_o = `EXC_CODE_INT;
        if (pcValid) begin
            if (intPending) begin
                resolved.interrupt     = 1'b1;
                excCode_o              = `EXC_CODE_INT;
            end else if (inFlags.fetchAddrErr) begin
                resolved.fetchAddrErr  = 1'b1;
                excCode_o              = `EXC_CODE_ADEL;   // fetch shares AdEL
            end else if (inFlags.reservedInstr) begin
                resolved.reservedInstr = 1'b1;
                excCode_o              = `EXC_CODE_RI;
            end else if (inFlags.syscall) begin
                resolved.syscall       = 1'b1;
                excCode_o              = `EXC_CODE_SYS;
            end else if (inFlags.breakPt) begin
                resolved.breakPt       = 1'b1;
                excCode_o              = `EXC_CODE_BP;
            end else if (inFlags.overflow) begin
                resolved.overflow      = 1'b1;
                excCode_o              = `EXC_CODE_OV;
            end else if (inFlags.storeAddrErr) begin
                resolved.storeAddrErr  = 1'b1;
                excCode_o              = `EXC_CODE_ADES;
            end else if (inFlags.loadAddrErr) begin
                resolved.loadAddrErr   = 1'b1;
                excCode_o              = `EXC_CODE_ADEL;
            end else if (inFlags.eret) begin
                resolved.eret          = 1'b1;      // code left at 0, unused
            end
        end
    end

    assign excType_o = resolved;
    assign eventHit  = |resolved;

    // ****************************************
    // action, flush and redirect
    // ****************************************
    always_comb begin
        if (!eventHit) begin
            excAction_o  = actNone;
            redirectPc_o = '0;
        end else if (resolved.eret) begin
            excAction_o  = actEret;
            redirectPc_o = cp0Latest_i.epc;     // return to bypassed epc
        end else begin
            excAction_o  = actException;
            redirectPc_o = `EXC_VECTOR;
        end
    end

    assign flush_o  = {4{eventHit}};            // whole pipe on any event
    assign regsWr_o = eventHit ? '0 : memStage_i.regsWr;   // kill the writes

endmodule

// File: src/cp0Bypass.sv
`timescale 1ns/1ps

`include "excUnit_params.svh"

// forwards a write-back cp0 write onto the stored values
// so the memory stage sees what it would after write-back
module cp0Bypass import excPkg::*; (
    input  cp0StateT    cp0State_i,     // registered cp0 values
    input  cp0WrT       cp0Wr_i,        // write from write-back stage
    output cp0StateT    cp0Latest_o     // values after the pending write
);

    // ****************************************
    // merge
    // ****************************************
    always_comb begin
        cp0Latest_o = cp0State_i;   // default: stored values pass through

        if (cp0Wr_i.we) begin
            case (cp0Wr_i.addr)
                `CP0_REG_STATUS: begin
                    cp0Latest_o.status = cp0Wr_i.data;      // fully writable
                end
                `CP0_REG_CAUSE: begin
                    // only the two software interrupt bits
                    cp0Latest_o.cause[9:8] = cp0Wr_i.data[9:8];
                end
                `CP0_REG_EPC: begin
                    cp0Latest_o.epc = cp0Wr_i.data;
                end
                default: begin
                    // other cp0 numbers not held here
                end
            endcase
        end
    end

endmodule

// File: src/excPkg.sv
`include "excUnit_params.svh"

package excPkg;

    // ****************************************
    // exception flags from earlier stages
    // ****************************************
    // msb first, same order as the resolve priority
    typedef struct packed {
        logic interrupt;        // set here from cp0, not trusted from upstream
        logic fetchAddrErr;
        logic reservedInstr;
        logic syscall;
        logic breakPt;
        logic overflow;
        logic storeAddrErr;
        logic loadAddrErr;
        logic eret;
    } excTypeT;

    typedef struct packed {
        logic rfWr;             // general register file
        logic hiloWr;           // hi/lo pair
        logic cp0Wr;            // coprocessor 0
    } regsWrT;

    // instruction sitting in the memory stage
    typedef struct packed {
        logic [`EXC_DATA_W-1:0] pc;
        logic                   isDelaySlot;
        excTypeT                excType;
        regsWrT                 regsWr;
    } memStageT;

    // cp0 write coming out of write-back
    typedef struct packed {
        logic                   we;
        logic [4:0]             addr;
        logic [`EXC_DATA_W-1:0] data;
    } cp0WrT;

    typedef struct packed {
        logic [`EXC_DATA_W-1:0] status;
        logic [`EXC_DATA_W-1:0] cause;
        logic [`EXC_DATA_W-1:0] epc;
    } cp0StateT;

    typedef struct packed {
        logic ifId;
        logic idEx;
        logic exMem;
        logic memWb;
    } flushT;

    typedef enum logic [1:0] {
        actNone      = 2'd0,
        actException = 2'd1,
        actEret      = 2'd2
    } excActionT;

    // ****************************************
    // apb slave port
    // ****************************************
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [7:0]             paddr;      // byte address
        logic [`EXC_DATA_W-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [`EXC_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apbRspT;

endpackage

// File: include/excUnit_params.svh
`ifndef EXC_UNIT_PARAMS_SVH
`define EXC_UNIT_PARAMS_SVH

// cpu word
`define EXC_DATA_W          32

// cp0 register numbers, also apb word index
`define CP0_REG_STATUS      5'd12
`define CP0_REG_CAUSE       5'd13
`define CP0_REG_EPC         5'd14

// reset values
`define CP0_STATUS_RESET    32'h0040_0000   // only BEV set
`define EXC_VECTOR          32'hBFC0_0380   // general exception entry, BEV=1

// ExcCode field values
`define EXC_CODE_INT        5'd0            // interrupt
`define EXC_CODE_ADEL       5'd4            // address error on load or fetch
`define EXC_CODE_ADES       5'd5            // address error on store
`define EXC_CODE_SYS        5'd8            // syscall
`define EXC_CODE_BP         5'd9            // break
`define EXC_CODE_RI         5'd10           // reserved instruction
`define EXC_CODE_OV         5'd12           // integer overflow

`endif
